// File: source/fdc_card_pkg.sv
`default_nettype none

package fdc_card_pkg;

   // CPU side
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  byte_t;

   // service port, bit 13 low selects the ROM
   typedef logic [13:0] sp_addr_t;

   typedef logic [12:0] rom_addr_t;   // 8 KiB DSR image
   typedef logic [7:0]  buf_pos_t;    // 256-byte sector
   typedef logic [2:0]  drive_vec_t;  // drive 1 in bit 0

   // window compare values, a_i is LSB-first
   localparam logic [7:0]  CRU_BASE = 8'h11;    // a_i[15:8]
   localparam logic [11:0] FDC_PAGE = 12'h5FF;  // a_i[15:4]
   localparam logic [2:0]  DSR_PAGE = 3'b010;   // a_i[15:13]

   // service handshake FSM
   typedef enum logic [1:0] {
      sp_idle,
      sp_busy,
      sp_done
   } sp_state_t;

endpackage

`default_nettype wire

// File: source/cru_control.sv
`timescale 1ns/1ps
`default_nettype none

module cru_control #(
   parameter int unsigned MOTOR_TICKS = 9421362
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clk_3mhz_en_i,
   input  fdc_card_pkg::cpu_addr_t  a_i,
   input  logic                     cruclk_i,
   input  logic                     fdc_hld_i,
   input  logic                     cru_select_i,
   output logic                     page_en_o,
   output logic                     wait_en_o,
   output logic                     hlt_o,
   output logic                     side_o,
   output fdc_card_pkg::drive_vec_t drive_sel_o,
   output logic                     motor_on_o,
   output logic                     cruin_o
);

   localparam int CNT_W = $clog2(MOTOR_TICKS + 1);

   logic [7:0]       cru_q;      // one latch per CRU index
   logic             trig_prev;
   logic             trig_edge;
   logic [CNT_W-1:0] count;      // remaining enable ticks

   // bit index in a_i[3:1], data in a_i[0]
   always_ff @(posedge clk) begin
      if (reset) begin
         cru_q <= '0;
      end else if (cruclk_i && cru_select_i) begin
         cru_q[a_i[3:1]] <= a_i[0];
      end
   end

   assign page_en_o   = cru_q[0];
   assign wait_en_o   = cru_q[2];
   assign hlt_o       = cru_q[3];
   assign side_o      = cru_q[7];
   assign drive_sel_o = cru_q[6:4] & {3{motor_on_o}};  // selects need the motor
   assign trig_edge   = cru_q[1] & ~trig_prev;

   // motor one-shot, retriggerable
   always_ff @(posedge clk) begin
      if (reset) begin
         motor_on_o <= 1'b0;
         trig_prev  <= 1'b0;
         count      <= '0;
      end else begin
         trig_prev <= cru_q[1];
         if (trig_edge) begin
            motor_on_o <= 1'b1;
            count      <= CNT_W'(MOTOR_TICKS);
         end else if (motor_on_o && clk_3mhz_en_i) begin
            if (count != '0) begin
               count <= count - 1'b1;
            end else begin
               motor_on_o <= 1'b0;  // expired
            end
         end
      end
   end

   always_comb begin
      case (a_i[3:1])
         3'd0:    cruin_o = fdc_hld_i;
         3'd1:    cruin_o = drive_sel_o[0];
         3'd2:    cruin_o = drive_sel_o[1];
         3'd3:    cruin_o = drive_sel_o[2];
         3'd4:    cruin_o = ~motor_on_o;
         3'd5:    cruin_o = 1'b0;
         3'd6:    cruin_o = 1'b1;
         default: cruin_o = side_o;
      endcase
   end

endmodule

`default_nettype wire

// File: source/bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
   input  logic                    clk,
   input  logic                    clk_3mhz_en_i,
   input  fdc_card_pkg::cpu_addr_t a_i,
   input  fdc_card_pkg::byte_t     d_i,
   input  logic                    memen_i,
   input  logic                    we_i,
   input  logic                    page_en_i,
   input  logic                    wait_en_i,
   input  logic                    motor_on_i,
   input  logic                    fdc_drq_i,
   input  logic                    fdc_intrq_i,
   input  fdc_card_pkg::byte_t     fdc_dout_i,
   input  fdc_card_pkg::byte_t     rom_q_i,
   output logic                    cru_select_o,
   output logic                    q_select_o,
   output logic                    dsr_read_o,
   output fdc_card_pkg::rom_addr_t rom_addr_o,
   output logic                    fdc_cs_o,
   output logic                    fdc_re_o,
   output logic                    fdc_we_o,
   output logic [1:0]              fdc_a_o,
   output fdc_card_pkg::byte_t     fdc_din_o,
   output fdc_card_pkg::byte_t     q_o,
   output logic                    ready_o
);

   import fdc_card_pkg::*;

   logic fdc_win;
   logic wait_done;

   assign cru_select_o = (a_i[15:8] == CRU_BASE);
   assign q_select_o   = page_en_i && (a_i[15:13] == DSR_PAGE);
   assign dsr_read_o   = q_select_o && memen_i && !we_i;
   assign rom_addr_o   = a_i[12:0];

   // controller registers, reads and writes at separate addresses
   assign fdc_win   = (a_i[15:4] == FDC_PAGE);
   assign fdc_cs_o  = page_en_i && memen_i && fdc_win;
   assign fdc_re_o  = fdc_cs_o && !a_i[0] && !a_i[3] && !we_i;
   assign fdc_we_o  = fdc_cs_o && !a_i[0] && a_i[3] && we_i;
   assign fdc_a_o   = {a_i[2], a_i[1]};
   assign fdc_din_o = ~d_i;   // controller bus is inverted

   assign q_o = fdc_win ? ~fdc_dout_i : rom_q_i;

   // CPU waits until the controller has something to say
   always_ff @(posedge clk) begin
      if (!fdc_cs_o) begin
         wait_done <= 1'b0;
      end else if (clk_3mhz_en_i && (fdc_drq_i || fdc_intrq_i || !motor_on_i)) begin
         wait_done <= 1'b1;
      end
   end

   assign ready_o = !fdc_cs_o || !wait_en_i || wait_done;

endmodule

`default_nettype wire

// File: source/dsr_rom.sv
`timescale 1ns/1ps
`default_nettype none

module dsr_rom (
   input  logic                    clk,
   input  logic                    dsr_read_i,
   input  fdc_card_pkg::rom_addr_t cpu_addr_i,
   input  logic                    sp_rd_i,
   input  logic                    sp_wr_i,
   input  fdc_card_pkg::rom_addr_t sp_addr_i,
   input  fdc_card_pkg::byte_t     sp_wdata_i,
   output fdc_card_pkg::byte_t     rom_q_o,
   output logic                    busy_o
);

   import fdc_card_pkg::*;

   localparam int DEPTH = 1 << $bits(rom_addr_t);

   byte_t mem [DEPTH];

   // single port, CPU read has priority
   always_ff @(posedge clk) begin
      if (dsr_read_i) begin
         rom_q_o <= mem[cpu_addr_i];
      end else if (sp_rd_i) begin
         rom_q_o <= mem[sp_addr_i];
      end else if (sp_wr_i) begin
         mem[sp_addr_i] <= sp_wdata_i;
      end
   end

   assign busy_o = dsr_read_i;  // service side retries

endmodule

`default_nettype wire

// File: source/sector_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sector_buffer (
   input  logic                   clk,
   input  logic                   reset,
   input  fdc_card_pkg::buf_pos_t buf_pos_i,
   input  fdc_card_pkg::byte_t    buf_wdata_i,
   input  logic                   buf_write_strobe_i,
   input  logic                   buf_read_strobe_i,
   input  logic                   header_strobe_i,
   input  logic [5:0]             drv_track_i,
   input  logic [4:0]             drv_sector_i,
   input  logic                   drv_ds_i,
   input  logic                   side_i,
   input  logic                   sp_rd_i,
   input  logic                   sp_wr_i,
   input  fdc_card_pkg::buf_pos_t sp_addr_i,
   input  fdc_card_pkg::byte_t    sp_wdata_i,
   output fdc_card_pkg::byte_t    buf_rdata_o,
   output fdc_card_pkg::byte_t    sp_rdata_o,
   output logic                   busy_o
);

   import fdc_card_pkg::*;

   byte_t mem [256];
   byte_t rd_q;      // array read data, both sides
   byte_t hdr_q;
   logic  is_header;

   always_ff @(posedge clk) begin
      if (buf_read_strobe_i) begin
         rd_q <= mem[buf_pos_i];
      end else if (buf_write_strobe_i) begin
         mem[buf_pos_i] <= buf_wdata_i;
      end else if (sp_rd_i) begin
         rd_q <= mem[sp_addr_i];
      end else if (sp_wr_i) begin
         mem[sp_addr_i] <= sp_wdata_i;
      end
   end

   assign busy_o = buf_read_strobe_i || buf_write_strobe_i;

   // ID field bytes, value left aligned
   always_ff @(posedge clk) begin
      if (header_strobe_i) begin
         case (buf_pos_i[2:0])
            3'd0:    hdr_q <= {drv_track_i, 2'b00};
            3'd1:    hdr_q <= {side_i & drv_ds_i, 7'b0};
            3'd2:    hdr_q <= {drv_sector_i, 3'b000};
            3'd3:    hdr_q <= 8'h80;  // size code
            default: hdr_q <= 8'h00;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         is_header <= 1'b0;
      end else begin
         is_header <= header_strobe_i;
      end
   end

   assign buf_rdata_o = is_header ? hdr_q : rd_q;
   assign sp_rdata_o  = rd_q;

endmodule

`default_nettype wire

// File: source/service_regs.sv
`timescale 1ns/1ps
`default_nettype none

module service_regs (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     sp_req_i,
   input  logic                     sp_we_i,
   input  fdc_card_pkg::sp_addr_t   sp_addr_i,
   input  fdc_card_pkg::byte_t      sp_wdata_i,
   input  fdc_card_pkg::byte_t      rom_q_i,
   input  logic                     rom_busy_i,
   input  fdc_card_pkg::byte_t      buf_q_i,
   input  logic                     buf_busy_i,
   input  fdc_card_pkg::drive_vec_t drive_sel_i,
   input  logic                     side_i,
   input  logic [5:0]               drv_track_i,
   input  fdc_card_pkg::byte_t      fdc_sector_i,
   input  fdc_card_pkg::byte_t      fdc_cmd_i,
   input  logic                     xfer_read_strobe_i,
   input  logic                     xfer_write_strobe_i,
   output logic                     sp_ack_o,
   output fdc_card_pkg::byte_t      sp_rdata_o,
   output logic                     rom_rd_o,
   output logic                     rom_wr_o,
   output logic                     buf_rd_o,
   output logic                     buf_wr_o,
   output fdc_card_pkg::drive_vec_t img_mounted_o,
   output fdc_card_pkg::drive_vec_t img_wp_o,
   output fdc_card_pkg::drive_vec_t img_strobe_o,
   output logic                     img_ds_o,
   output logic                     img_dd_o,
   output logic [4:0]               img_sps_o,
   output logic                     wprt_o
);

   import fdc_card_pkg::*;

   sp_state_t  state;
   logic       rom_sel;
   logic       buf_sel;
   logic       reg_sel;
   logic       go;       // access cycle
   logic       stall;
   logic       reg_wr;
   byte_t      reg_q;
   drive_vec_t img_rd;
   drive_vec_t img_wr;
   logic       xfer_ack;

   assign rom_sel = !sp_addr_i[13];
   assign buf_sel = (sp_addr_i[13:12] == 2'b10);
   assign reg_sel = (sp_addr_i[13:12] == 2'b11);

   assign go       = (state == sp_busy);
   assign stall    = (rom_sel && rom_busy_i) || (buf_sel && buf_busy_i);
   assign rom_rd_o = go && rom_sel && !sp_we_i;
   assign rom_wr_o = go && rom_sel && sp_we_i;
   assign buf_rd_o = go && buf_sel && !sp_we_i;
   assign buf_wr_o = go && buf_sel && sp_we_i;
   assign reg_wr   = go && reg_sel && sp_we_i;

   // four-phase handshake, busy memory repeats the strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= sp_idle;
         sp_ack_o <= 1'b0;
      end else begin
         case (state)
            sp_idle: if (sp_req_i) state <= sp_busy;
            sp_busy: if (!stall) state <= sp_done;
            default: begin
               if (!sp_ack_o) begin
                  sp_ack_o <= 1'b1;
               end else if (!sp_req_i) begin
                  sp_ack_o <= 1'b0;
                  state    <= sp_idle;
               end
            end
         endcase
      end
   end

   // memory read data lands the cycle after the strobe
   always_ff @(posedge clk) begin
      if (state == sp_done && !sp_ack_o) begin
         sp_rdata_o <= rom_sel ? rom_q_i : (buf_sel ? buf_q_i : reg_q);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         img_mounted_o <= '0;
         img_wp_o      <= '0;
         img_strobe_o  <= '0;
         img_ds_o      <= 1'b0;
         img_dd_o      <= 1'b0;
         img_sps_o     <= '0;
         img_rd        <= '0;
         img_wr        <= '0;
         xfer_ack      <= 1'b0;
      end else begin
         img_strobe_o <= '0;
         if (xfer_read_strobe_i) img_rd <= drive_sel_i;
         if (xfer_write_strobe_i) img_wr <= drive_sel_i;
         if (reg_wr) begin
            case (sp_addr_i[3:0])
               4'd0: begin
                  img_strobe_o  <= img_mounted_o ^ sp_wdata_i[6:4];  // changed images
                  img_mounted_o <= sp_wdata_i[6:4];
                  img_wp_o      <= sp_wdata_i[2:0];
               end
               4'd2: begin
                  xfer_ack <= sp_wdata_i[0];
                  if (sp_wdata_i[0] && !xfer_ack) begin
                     img_rd <= '0;
                     img_wr <= '0;
                  end
               end
               4'd3: begin
                  img_ds_o  <= sp_wdata_i[7];
                  img_dd_o  <= sp_wdata_i[6];
                  img_sps_o <= sp_wdata_i[4:0];
               end
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (sp_addr_i[3:0])
         4'd0:    reg_q = {1'b0, img_mounted_o, 1'b0, img_wp_o};
         4'd1:    reg_q = {1'b0, img_rd, 1'b0, img_wr};
         4'd2:    reg_q = {7'b0, xfer_ack};
         4'd3:    reg_q = {img_ds_o, img_dd_o, 1'b0, img_sps_o};
         4'd4:    reg_q = {1'b0, drv_track_i, side_i};
         4'd5:    reg_q = fdc_sector_i;
         4'd6:    reg_q = fdc_cmd_i;
         default: reg_q = '0;
      endcase
   end

   assign wprt_o = |(img_wp_o & drive_sel_i);

endmodule

`default_nettype wire

// File: source/fdc_card.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_card #(
   parameter int unsigned MOTOR_TICKS = 9421362
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     clk_3mhz_en_i,
   input  fdc_card_pkg::cpu_addr_t  a_i,
   input  fdc_card_pkg::byte_t      d_i,
   input  logic                     memen_i,
   input  logic                     we_i,
   input  logic                     cruclk_i,
   output fdc_card_pkg::byte_t      q_o,
   output logic                     q_select_o,
   output logic                     cru_select_o,
   output logic                     cruin_o,
   output logic                     ready_o,
   output logic                     led_o,
   output logic                     fdc_cs_o,
   output logic                     fdc_re_o,
   output logic                     fdc_we_o,
   output logic [1:0]               fdc_a_o,
   output fdc_card_pkg::byte_t      fdc_din_o,
   output logic                     hlt_o,
   output logic                     motor_on_o,
   output fdc_card_pkg::drive_vec_t drive_sel_o,
   output logic                     side_o,
   output logic                     wprt_o,
   output fdc_card_pkg::byte_t      buf_rdata_o,
   output logic                     track0_o,
   input  fdc_card_pkg::byte_t      fdc_dout_i,
   input  logic                     fdc_drq_i,
   input  logic                     fdc_intrq_i,
   input  logic                     fdc_hld_i,
   input  fdc_card_pkg::byte_t      fdc_sector_i,
   input  fdc_card_pkg::byte_t      fdc_cmd_i,
   input  fdc_card_pkg::buf_pos_t   buf_pos_i,
   input  fdc_card_pkg::byte_t      buf_wdata_i,
   input  logic                     buf_write_strobe_i,
   input  logic                     buf_read_strobe_i,
   input  logic                     header_strobe_i,
   input  logic                     xfer_read_strobe_i,
   input  logic                     xfer_write_strobe_i,
   input  logic [5:0]               drv_track_i,
   input  logic [4:0]               drv_sector_i,
   input  logic                     drv_ds_i,
   output fdc_card_pkg::drive_vec_t img_mounted_o,
   output fdc_card_pkg::drive_vec_t img_wp_o,
   output fdc_card_pkg::drive_vec_t img_strobe_o,
   output logic                     img_ds_o,
   output logic                     img_dd_o,
   output logic [4:0]               img_sps_o,
   input  logic                     sp_req_i,
   input  logic                     sp_we_i,
   input  fdc_card_pkg::sp_addr_t   sp_addr_i,
   input  fdc_card_pkg::byte_t      sp_wdata_i,
   output logic                     sp_ack_o,
   output fdc_card_pkg::byte_t      sp_rdata_o
);

   import fdc_card_pkg::*;

   logic      page_en;
   logic      wait_en;
   logic      dsr_read;
   rom_addr_t rom_addr;
   byte_t     rom_q;
   byte_t     buf_q;
   logic      rom_busy;
   logic      buf_busy;
   logic      rom_rd;
   logic      rom_wr;
   logic      buf_rd;
   logic      buf_wr;

   assign led_o    = page_en;
   assign track0_o = (drv_track_i == 6'd0);

   cru_control #(
      .MOTOR_TICKS(MOTOR_TICKS)
   ) i_cru_control (
      .clk          (clk),
      .reset        (reset),
      .clk_3mhz_en_i(clk_3mhz_en_i),
      .a_i          (a_i),
      .cruclk_i     (cruclk_i),
      .fdc_hld_i    (fdc_hld_i),
      .cru_select_i (cru_select_o),
      .page_en_o    (page_en),
      .wait_en_o    (wait_en),
      .hlt_o        (hlt_o),
      .side_o       (side_o),
      .drive_sel_o  (drive_sel_o),
      .motor_on_o   (motor_on_o),
      .cruin_o      (cruin_o)
   );

   bus_decode i_bus_decode (
      .clk          (clk),
      .clk_3mhz_en_i(clk_3mhz_en_i),
      .a_i          (a_i),
      .d_i          (d_i),
      .memen_i      (memen_i),
      .we_i         (we_i),
      .page_en_i    (page_en),
      .wait_en_i    (wait_en),
      .motor_on_i   (motor_on_o),
      .fdc_drq_i    (fdc_drq_i),
      .fdc_intrq_i  (fdc_intrq_i),
      .fdc_dout_i   (fdc_dout_i),
      .rom_q_i      (rom_q),
      .cru_select_o (cru_select_o),
      .q_select_o   (q_select_o),
      .dsr_read_o   (dsr_read),
      .rom_addr_o   (rom_addr),
      .fdc_cs_o     (fdc_cs_o),
      .fdc_re_o     (fdc_re_o),
      .fdc_we_o     (fdc_we_o),
      .fdc_a_o      (fdc_a_o),
      .fdc_din_o    (fdc_din_o),
      .q_o          (q_o),
      .ready_o      (ready_o)
   );

   dsr_rom i_dsr_rom (
      .clk       (clk),
      .dsr_read_i(dsr_read),
      .cpu_addr_i(rom_addr),
      .sp_rd_i   (rom_rd),
      .sp_wr_i   (rom_wr),
      .sp_addr_i (sp_addr_i[12:0]),
      .sp_wdata_i(sp_wdata_i),
      .rom_q_o   (rom_q),
      .busy_o    (rom_busy)
   );

   sector_buffer i_sector_buffer (
      .clk               (clk),
      .reset             (reset),
      .buf_pos_i         (buf_pos_i),
      .buf_wdata_i       (buf_wdata_i),
      .buf_write_strobe_i(buf_write_strobe_i),
      .buf_read_strobe_i (buf_read_strobe_i),
      .header_strobe_i   (header_strobe_i),
      .drv_track_i       (drv_track_i),
      .drv_sector_i      (drv_sector_i),
      .drv_ds_i          (drv_ds_i),
      .side_i            (side_o),
      .sp_rd_i           (buf_rd),
      .sp_wr_i           (buf_wr),
      .sp_addr_i         (sp_addr_i[7:0]),
      .sp_wdata_i        (sp_wdata_i),
      .buf_rdata_o       (buf_rdata_o),
      .sp_rdata_o        (buf_q),
      .busy_o            (buf_busy)
   );

   service_regs i_service_regs (
      .clk                (clk),
      .reset              (reset),
      .sp_req_i           (sp_req_i),
      .sp_we_i            (sp_we_i),
      .sp_addr_i          (sp_addr_i),
      .sp_wdata_i         (sp_wdata_i),
      .rom_q_i            (rom_q),
      .rom_busy_i         (rom_busy),
      .buf_q_i            (buf_q),
      .buf_busy_i         (buf_busy),
      .drive_sel_i        (drive_sel_o),
      .side_i             (side_o),
      .drv_track_i        (drv_track_i),
      .fdc_sector_i       (fdc_sector_i),
      .fdc_cmd_i          (fdc_cmd_i),
      .xfer_read_strobe_i (xfer_read_strobe_i),
      .xfer_write_strobe_i(xfer_write_strobe_i),
      .sp_ack_o           (sp_ack_o),
      .sp_rdata_o         (sp_rdata_o),
      .rom_rd_o           (rom_rd),
      .rom_wr_o           (rom_wr),
      .buf_rd_o           (buf_rd),
      .buf_wr_o           (buf_wr),
      .img_mounted_o      (img_mounted_o),
      .img_wp_o           (img_wp_o),
      .img_strobe_o       (img_strobe_o),
      .img_ds_o           (img_ds_o),
      .img_dd_o           (img_dd_o),
      .img_sps_o          (img_sps_o),
      .wprt_o             (wprt_o)
   );

endmodule

`default_nettype wire

// File: dv/fdc_card_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_card_tb;

   import fdc_card_pkg::*;

   localparam int MOTOR_TICKS = 20;
   localparam int N_CRU = 40;
   localparam int N_ROM = 32;
   localparam int N_BUF = 24;
   localparam int N_IMG = 8;
   localparam int N_OPS = N_CRU + 3 * N_ROM + 5 * N_BUF + 4 * N_IMG + 80;
   localparam time TIMEOUT = N_OPS * 200 * 100;  // 200 cycles per operation

   logic clk = 1'b0;
   logic reset = 1'b1;
   logic clk_3mhz_en_i = 1'b0;
   cpu_addr_t a_i = '0;
   byte_t d_i = '0;
   logic memen_i = 1'b0;
   logic we_i = 1'b0;
   logic cruclk_i = 1'b0;
   byte_t fdc_dout_i = '0;
   byte_t fdc_sector_i = '0;
   byte_t fdc_cmd_i = '0;
   byte_t buf_wdata_i = '0;
   logic fdc_drq_i = 1'b0;
   logic fdc_intrq_i = 1'b0;
   logic fdc_hld_i = 1'b0;
   buf_pos_t buf_pos_i = '0;
   logic buf_write_strobe_i = 1'b0;
   logic buf_read_strobe_i = 1'b0;
   logic header_strobe_i = 1'b0;
   logic xfer_read_strobe_i = 1'b0;
   logic xfer_write_strobe_i = 1'b0;
   logic [5:0] drv_track_i = '0;
   logic [4:0] drv_sector_i = '0;
   logic drv_ds_i = 1'b0;
   logic sp_req_i = 1'b0;
   logic sp_we_i = 1'b0;
   sp_addr_t sp_addr_i = '0;
   byte_t sp_wdata_i = '0;

   byte_t q_o;
   byte_t fdc_din_o;
   byte_t buf_rdata_o;
   byte_t sp_rdata_o;
   logic q_select_o;
   logic cru_select_o;
   logic cruin_o;
   logic ready_o;
   logic led_o;
   logic fdc_cs_o;
   logic fdc_re_o;
   logic fdc_we_o;
   logic hlt_o;
   logic motor_on_o;
   logic side_o;
   logic wprt_o;
   logic track0_o;
   logic [1:0] fdc_a_o;
   drive_vec_t drive_sel_o;
   drive_vec_t img_mounted_o;
   drive_vec_t img_wp_o;
   drive_vec_t img_strobe_o;
   logic img_ds_o;
   logic img_dd_o;
   logic sp_ack_o;
   logic [4:0] img_sps_o;

   integer seed = 67;
   int en_div = 0;
   logic [7:0] cru_model = '0;
   drive_vec_t mount_model = '0;
   byte_t rom_model [1 << $bits(rom_addr_t)];
   rom_addr_t rom_list [$];
   byte_t buf_model [256];
   bit buf_used [256];
   int buf_written [$];
   drive_vec_t strobe_or;
   int strobe_cycles;

   fdc_card #(.MOTOR_TICKS(MOTOR_TICKS)) i_fdc_card (.*);

   always #50 clk = ~clk;

   // enable on every third cycle
   always @(posedge clk) begin
      #1;
      en_div = (en_div == 2) ? 0 : en_div + 1;
      clk_3mhz_en_i = (en_div == 2);
   end

   always @(negedge clk) begin
      if (img_strobe_o != '0) begin
         strobe_or |= img_strobe_o;
         strobe_cycles++;
      end
   end

   initial begin
      #(TIMEOUT);
      $display("timeout: the DUT stopped answering before the tests finished");
      $display("Something failed");
      $fatal(1, "watchdog expired");
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
         $display("Something failed");
         $fatal(1, "mismatch");
      end
   endtask

   task automatic next_cycle;
      @(posedge clk);
      #1;
   endtask

   task automatic cru_write(input int idx, input logic val);
      a_i = {CRU_BASE, 4'h0, idx[2:0], val};
      cruclk_i = 1'b1;
      next_cycle();
      cruclk_i = 1'b0;
      cru_model[idx] = val;
   endtask

   // expected readback, motor state given by the caller
   function automatic logic cru_expect(input int idx, input logic motor);
      case (idx)
         0: return fdc_hld_i;
         1, 2, 3: return cru_model[idx + 3] & motor;
         4: return ~motor;
         5: return 1'b0;
         6: return 1'b1;
         default: return cru_model[7];
      endcase
   endfunction

   task automatic sp_access(input logic we, input sp_addr_t addr, input byte_t wdata,
                            output byte_t rdata);
      sp_we_i = we;
      sp_addr_i = addr;
      sp_wdata_i = wdata;
      sp_req_i = 1'b1;
      while (!sp_ack_o) next_cycle();
      rdata = sp_rdata_o;
      sp_req_i = 1'b0;
      while (sp_ack_o) next_cycle();
   endtask

   task automatic sp_write(input sp_addr_t addr, input byte_t wdata);
      byte_t dummy;
      sp_access(1'b1, addr, wdata, dummy);
   endtask

   task automatic buf_strobe(input logic wr, input buf_pos_t pos, input byte_t wdata,
                             output byte_t rdata);
      buf_pos_i = pos;
      buf_wdata_i = wdata;
      buf_write_strobe_i = wr;
      buf_read_strobe_i = !wr;
      next_cycle();
      buf_write_strobe_i = 1'b0;
      buf_read_strobe_i = 1'b0;
      rdata = buf_rdata_o;
   endtask

   function automatic byte_t header_byte(input buf_pos_t pos);
      case (pos[2:0])
         3'd0: return {drv_track_i, 2'b00};
         3'd1: return {cru_model[7] & drv_ds_i, 7'b0};
         3'd2: return {drv_sector_i, 3'b000};
         3'd3: return 8'h80;
         default: return 8'h00;
      endcase
   endfunction

   // motor on for MOTOR_TICKS+1 enable ticks, then off
   task automatic check_motor_run;
      int ticks;
      ticks = 0;
      while (ticks < MOTOR_TICKS + 1) begin
         @(negedge clk);
         check_value("motor_on_o", motor_on_o, 1);
         check_value("drive_sel_o", drive_sel_o, cru_model[6:4]);
         if (clk_3mhz_en_i) ticks++;
      end
      @(negedge clk);
      check_value("motor_on_o", motor_on_o, 0);
      check_value("drive_sel_o", drive_sel_o, 0);
      #51;
   endtask

   task automatic motor_trigger;
      cru_write(1, 1'b0);
      cru_write(1, 1'b1);
      next_cycle();
   endtask

   // one enable tick every third cycle
   task automatic wait_ready(input string name);
      int n;
      n = 0;
      while (!ready_o && n < 4) begin
         next_cycle();
         n++;
      end
      check_value(name, ready_o, 1);
   endtask

   initial begin
      int i;
      int j;
      int ticks;
      rom_addr_t ra;
      buf_pos_t bp;
      byte_t d;
      byte_t r;
      byte_t exp_b;
      drive_vec_t sel_a;
      drive_vec_t sel_b;

      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      next_cycle();

      // CRU bits after reset and random writes, motor stays off
      check_value("sp_ack_o", sp_ack_o, 0);
      check_value("img_strobe_o", img_strobe_o, 0);
      for (i = 0; i < 8; i++) begin
         a_i = {CRU_BASE, 4'h0, i[2:0], 1'b0};
         #1 check_value("cruin_o", cruin_o, cru_expect(i, 1'b0));
         check_value("cru_select_o", cru_select_o, 1);
         check_value("q_select_o", q_select_o, 0);
      end
      for (i = 0; i < N_CRU; i++) begin
         j = $unsigned($random(seed)) % 8;
         if (j == 1) j = 7;
         fdc_hld_i = $random(seed);
         cru_write(j, $random(seed));
         for (j = 0; j < 8; j++) begin
            a_i = {CRU_BASE, 4'h0, j[2:0], 1'b0};
            #1 check_value("cruin_o", cruin_o, cru_expect(j, 1'b0));
         end
         check_value("led_o", led_o, cru_model[0]);
         check_value("hlt_o", hlt_o, cru_model[3]);
         check_value("side_o", side_o, cru_model[7]);
      end

      // motor one-shot and retrigger
      cru_write(4, 1'b1);
      cru_write(6, 1'b1);
      motor_trigger();
      check_value("motor_on_o", motor_on_o, 1);
      check_motor_run();
      motor_trigger();
      ticks = 0;
      while (ticks < 10) begin
         @(negedge clk);
         if (clk_3mhz_en_i) ticks++;
      end
      #51 motor_trigger();
      check_motor_run();

      // ROM through service port and CPU window
      cru_write(0, 1'b1);
      for (i = 0; i < N_ROM; i++) begin
         ra = $random(seed);
         if (ra[12:4] == 9'h1FF) ra[12] = 1'b0;  // keep clear of controller window
         d = $random(seed);
         rom_model[ra] = d;
         rom_list.push_back(ra);
         sp_write({1'b0, ra}, d);
      end
      for (i = 0; i < rom_list.size(); i++) begin
         ra = rom_list[i];
         a_i = {DSR_PAGE, ra};
         memen_i = 1'b1;
         next_cycle();
         memen_i = 1'b0;
         check_value("q_select_o", q_select_o, 1);
         check_value("q_o", q_o, rom_model[ra]);
         sp_access(1'b0, {1'b0, ra}, 8'h00, r);
         check_value("sp_rdata_o rom", r, rom_model[ra]);
      end

      // sector buffer both directions
      for (i = 0; i < N_BUF; i++) begin
         bp = $random(seed);
         d = $random(seed);
         if (!buf_used[bp]) begin
            buf_written.push_back(bp);
            buf_used[bp] = 1'b1;
         end
         buf_model[bp] = d;
         if (i % 2 == 0) begin
            sp_write({2'b10, 4'h0, bp}, d);
            buf_strobe(1'b0, bp, 8'h00, r);
            check_value("buf_rdata_o", r, d);
         end else begin
            buf_strobe(1'b1, bp, d, r);
            sp_access(1'b0, {2'b10, 4'h0, bp}, 8'h00, r);
            check_value("sp_rdata_o buf", r, d);
         end
      end
      for (i = 0; i < N_BUF; i++) begin
         drv_track_i = $random(seed);
         if (i % 4 == 0) drv_track_i = '0;  // cover track 0
         drv_sector_i = $random(seed);
         drv_ds_i = $random(seed);
         bp = $random(seed);
         buf_pos_i = bp;
         header_strobe_i = 1'b1;
         next_cycle();
         header_strobe_i = 1'b0;
         check_value("buf_rdata_o header", buf_rdata_o, header_byte(bp));
         check_value("track0_o", track0_o, drv_track_i == 6'd0);
      end
      // service write while the controller keeps the buffer busy
      for (i = 0; i < N_BUF / 4; i++) begin
         bp = 8'hF0 + i[7:0];
         d = $random(seed);
         fork
            sp_write({2'b10, 4'h0, bp}, d);
            for (j = 0; j < 4; j++) begin
               buf_strobe(1'b0, buf_written[j], 8'h00, r);
               check_value("buf_rdata_o overlap", r, buf_model[buf_written[j]]);
            end
         join
         buf_model[bp] = d;
         sp_access(1'b0, {2'b10, 4'h0, bp}, 8'h00, r);
         check_value("sp_rdata_o overlap", r, d);
      end

      // image registers
      for (i = 0; i < N_IMG; i++) begin
         d = $random(seed);
         strobe_or = '0;
         strobe_cycles = 0;
         sp_write(14'h3000, d);
         next_cycle();
         check_value("img_strobe_o", strobe_or, mount_model ^ d[6:4]);
         check_value("strobe cycles", strobe_cycles, (mount_model ^ d[6:4]) != 0);
         mount_model = d[6:4];
         check_value("img_mounted_o", img_mounted_o, d[6:4]);
         check_value("img_wp_o", img_wp_o, d[2:0]);
      end
      motor_trigger();
      for (i = 0; i < 3; i++) begin
         d = $random(seed);
         sp_write(14'h3000, d);
         check_value("wprt_o", wprt_o, |(d[2:0] & cru_model[6:4]));
      end
      motor_trigger();
      sel_a = cru_model[6:4];
      xfer_read_strobe_i = 1'b1;
      next_cycle();
      xfer_read_strobe_i = 1'b0;
      cru_write(5, 1'b1);
      sel_b = cru_model[6:4];
      xfer_write_strobe_i = 1'b1;
      next_cycle();
      xfer_write_strobe_i = 1'b0;
      sp_access(1'b0, 14'h3001, 8'h00, r);
      check_value("rd/wr flags", r, {1'b0, sel_a, 1'b0, sel_b});
      sp_write(14'h3002, 8'h00);
      sp_write(14'h3002, 8'h01);
      sp_access(1'b0, 14'h3001, 8'h00, r);
      check_value("flags cleared", r, 0);
      d = $random(seed);
      sp_write(14'h3003, d);
      check_value("geometry", {img_ds_o, img_dd_o, img_sps_o}, {d[7:6], d[4:0]});
      fdc_sector_i = $random(seed);
      sp_access(1'b0, 14'h3005, 8'h00, r);
      check_value("reg fdc sector", r, fdc_sector_i);
      fdc_cmd_i = $random(seed);
      sp_access(1'b0, 14'h3006, 8'h00, r);
      check_value("reg fdc cmd", r, fdc_cmd_i);
      sp_access(1'b0, 14'h3004, 8'h00, r);
      check_value("reg track/side", r, {1'b0, drv_track_i, cru_model[7]});

      // wait states and inverted controller reads
      cru_write(2, 1'b1);
      motor_trigger();
      fdc_dout_i = $random(seed);
      a_i = 16'h5FF0;
      memen_i = 1'b1;
      for (i = 0; i < 6; i++) begin
         #1 check_value("ready_o", ready_o, 0);
         next_cycle();
      end
      exp_b = ~fdc_dout_i;
      check_value("fdc_cs_o", fdc_cs_o, 1);
      check_value("fdc_re_o", fdc_re_o, 1);
      check_value("q_o fdc", q_o, exp_b);
      fdc_drq_i = 1'b1;
      wait_ready("ready_o drq");
      memen_i = 1'b0;
      #1 check_value("ready_o deselected", ready_o, 1);
      check_value("fdc_cs_o", fdc_cs_o, 0);
      fdc_drq_i = 1'b0;
      next_cycle();
      memen_i = 1'b1;
      #1 check_value("ready_o reselected", ready_o, 0);
      fdc_intrq_i = 1'b1;
      wait_ready("ready_o intrq");
      fdc_intrq_i = 1'b0;
      memen_i = 1'b0;
      next_cycle();

      // controller register write, data bus inverted
      j = $unsigned($random(seed)) % 4;
      d = $random(seed);
      a_i = {FDC_PAGE, 1'b1, j[1:0], 1'b0};
      d_i = d;
      we_i = 1'b1;
      memen_i = 1'b1;
      exp_b = ~d;
      #1 check_value("fdc_we_o", fdc_we_o, 1);
      check_value("fdc_re_o write", fdc_re_o, 0);
      check_value("fdc_a_o", fdc_a_o, j[1:0]);
      check_value("fdc_din_o", fdc_din_o, exp_b);
      memen_i = 1'b0;
      we_i = 1'b0;
      next_cycle();

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
source/fdc_card_pkg.sv
source/cru_control.sv
source/bus_decode.sv
source/dsr_rom.sv
source/sector_buffer.sv
source/service_regs.sv
source/fdc_card.sv
dv/fdc_card_tb.sv
